/* include/i2s_rx_params.svh */
// ----------------------------------------------------------
// Sizing macros for the I2S receive path
// Sample width, FIFO depth and level count width
// ----------------------------------------------------------

`ifndef I2S_RX_PARAMS_SVH
`define I2S_RX_PARAMS_SVH

// Audio sample width in bits
`define I2S_RX_SAMPLE_W 16

// Entries per receive FIFO, must be a power of two
`define I2S_RX_FIFO_DEPTH 32

// Level count width, log2 of the depth plus one
`define I2S_RX_LEVEL_W ($clog2(`I2S_RX_FIFO_DEPTH) + 1)

`endif

/* logic/i2s_rx_pkg.sv */
// ----------------------------------------------------------
// Shared types for the I2S receive path
// Sample struct, mono word union, FIFO status struct
// ----------------------------------------------------------

`default_nettype none

`include "i2s_rx_params.svh"

package i2s_rx_pkg;

    // One recovered sample with its channel flag
    typedef struct packed {
        logic                        right;
        logic [`I2S_RX_SAMPLE_W-1:0] data;
    } sample_t;

    // Two samples of one channel, newer one on top
    typedef struct packed {
        logic [`I2S_RX_SAMPLE_W-1:0] newer;
        logic [`I2S_RX_SAMPLE_W-1:0] older;
    } mono_pair_t;

    // Packer writes the pair view, bus reads the raw word
    typedef union packed {
        logic [2*`I2S_RX_SAMPLE_W-1:0] raw;
        mono_pair_t                    pair;
    } mono_word_u;

    // Read-side flags and fill level of one FIFO
    typedef struct packed {
        logic                       full;
        logic                       empty;
        logic [`I2S_RX_LEVEL_W-1:0] level;
    } fifo_status_t;

endpackage

`default_nettype wire

/* logic/i2s_rx_deserializer.sv */
// ----------------------------------------------------------
// I2S serial to parallel converter, bit clock domain
// Word select edge detect, MSB first shift, sample strobe
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "i2s_rx_params.svh"

module i2s_rx_deserializer
(
    input  logic                i2s_clk_i,
    input  logic                rst_i,
    input  logic                i2s_ws_i,
    input  logic                i2s_sd_i,
    output i2s_rx_pkg::sample_t sample_o,
    output logic                sample_vld_o
);

    localparam int               CNT_W    = $clog2(`I2S_RX_SAMPLE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`I2S_RX_SAMPLE_W - 1);

    logic                        primed_q;
    logic                        ws_q;
    logic                        ws_qq;
    logic                        slot_start;
    logic                        last_bit;
    logic                        slot_right_q;
    logic [CNT_W-1:0]            bit_cnt_q;
    logic [`I2S_RX_SAMPLE_W-2:0] shift_q;

    // Word select changed one bit ago, MSB is on the line now
    assign slot_start = primed_q & (ws_q ^ ws_qq);
    assign last_bit   = (bit_cnt_q == LAST_BIT) & ~slot_start;

    // ------------------------------------------------------
    // Slot tracking
    // ------------------------------------------------------
    always_ff @(posedge i2s_clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            primed_q     <= 1'b0;
            ws_q         <= 1'b0;
            ws_qq        <= 1'b0;
            slot_right_q <= 1'b0;
            bit_cnt_q    <= '0;
            sample_vld_o <= 1'b0;
        end
        else
        begin
            primed_q     <= 1'b1;
            ws_q         <= i2s_ws_i;
            // First edge after reset loads both copies, so no false slot start
            ws_qq        <= primed_q ? ws_q : i2s_ws_i;
            sample_vld_o <= 1'b0;
            if (slot_start)
            begin
                slot_right_q <= ws_q;
                bit_cnt_q    <= CNT_W'(1);
            end
            else if (last_bit)
            begin
                bit_cnt_q    <= '0;
                sample_vld_o <= 1'b1;
            end
            else if (bit_cnt_q != '0)
            begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    // Data path, shifts on every bit clock
    always_ff @(posedge i2s_clk_i)
    begin
        shift_q <= {shift_q[`I2S_RX_SAMPLE_W-3:0], i2s_sd_i};
        if (last_bit)
        begin
            sample_o.data  <= {shift_q, i2s_sd_i};
            sample_o.right <= slot_right_q;
        end
    end

    // At most one sample per slot
    a_vld_single: assert property (@(posedge i2s_clk_i) disable iff (rst_i)
        sample_vld_o |=> !sample_vld_o)
        else $error("sample strobe high on two consecutive bit clocks");

endmodule

`default_nettype wire

/* logic/i2s_async_fifo.sv */
// ----------------------------------------------------------
// Dual-clock FIFO with gray coded pointers
// Write side full flag, read side empty, full and level
// Head entry shown combinationally on the read port
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "i2s_rx_params.svh"

module i2s_async_fifo
#(
    parameter int DATA_W = `I2S_RX_SAMPLE_W,
    parameter int DEPTH  = `I2S_RX_FIFO_DEPTH
)
(
    input  logic                     wr_clk_i,
    input  logic                     wr_rst_i,
    input  logic                     wr_en_i,
    input  logic [DATA_W-1:0]        wr_data_i,
    output logic                     wr_full_o,

    input  logic                     rd_clk_i,
    input  logic                     rd_rst_i,
    input  logic                     rd_en_i,
    output logic [DATA_W-1:0]        rd_data_o,
    output i2s_rx_pkg::fifo_status_t rd_status_o
);

    localparam int AW    = $clog2(DEPTH);
    localparam int PTR_W = AW + 1;

    logic [DATA_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0]  wr_bin_q;
    logic [PTR_W-1:0]  wr_bin_nxt;
    logic [PTR_W-1:0]  wr_gray_q;
    logic [PTR_W-1:0]  rd_gray_w1_q;
    logic [PTR_W-1:0]  rd_gray_w2_q;
    logic              push;

    logic [PTR_W-1:0]  rd_bin_q;
    logic [PTR_W-1:0]  rd_bin_nxt;
    logic [PTR_W-1:0]  rd_gray_q;
    logic [PTR_W-1:0]  wr_gray_r1_q;
    logic [PTR_W-1:0]  wr_gray_r2_q;
    logic [PTR_W-1:0]  level;
    logic              pop;

    function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
        logic [PTR_W-1:0] b;
        b[PTR_W-1] = g[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ------------------------------------------------------
    // Write side
    // ------------------------------------------------------
    // Full when the pointers differ only in the two top gray bits
    assign wr_full_o  = (wr_gray_q == {~rd_gray_w2_q[PTR_W-1:PTR_W-2],
                                       rd_gray_w2_q[PTR_W-3:0]});
    assign push       = wr_en_i & ~wr_full_o;
    assign wr_bin_nxt = wr_bin_q + PTR_W'(push);

    always_ff @(posedge wr_clk_i or posedge wr_rst_i)
    begin
        if (wr_rst_i)
        begin
            wr_bin_q     <= '0;
            wr_gray_q    <= '0;
            rd_gray_w1_q <= '0;
            rd_gray_w2_q <= '0;
        end
        else
        begin
            wr_bin_q     <= wr_bin_nxt;
            wr_gray_q    <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            rd_gray_w1_q <= rd_gray_q;
            rd_gray_w2_q <= rd_gray_w1_q;
        end
    end

    always_ff @(posedge wr_clk_i)
    begin
        if (push)
        begin
            mem[wr_bin_q[AW-1:0]] <= wr_data_i;
        end
    end

    // ------------------------------------------------------
    // Read side
    // ------------------------------------------------------
    assign level      = gray2bin(wr_gray_r2_q) - rd_bin_q;
    assign pop        = rd_en_i & ~rd_status_o.empty;
    assign rd_bin_nxt = rd_bin_q + PTR_W'(pop);

    always_ff @(posedge rd_clk_i or posedge rd_rst_i)
    begin
        if (rd_rst_i)
        begin
            rd_bin_q     <= '0;
            rd_gray_q    <= '0;
            wr_gray_r1_q <= '0;
            wr_gray_r2_q <= '0;
        end
        else
        begin
            rd_bin_q     <= rd_bin_nxt;
            rd_gray_q    <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            wr_gray_r1_q <= wr_gray_q;
            wr_gray_r2_q <= wr_gray_r1_q;
        end
    end

    assign rd_data_o         = mem[rd_bin_q[AW-1:0]];
    assign rd_status_o.level = `I2S_RX_LEVEL_W'(level);
    assign rd_status_o.empty = (level == '0);
    assign rd_status_o.full  = (level == PTR_W'(DEPTH));

    // Write side full flag must hold the synchronized level in range
    a_level_max: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
        level <= PTR_W'(DEPTH))
        else $error("FIFO level above depth");

    // Flags from the level agree with a direct gray pointer compare
    a_flags_gray: assert property (@(posedge rd_clk_i) disable iff (rd_rst_i)
        (rd_status_o.empty == (wr_gray_r2_q == rd_gray_q)) &&
        (rd_status_o.full == (wr_gray_r2_q == {~rd_gray_q[PTR_W-1:PTR_W-2],
                                                rd_gray_q[PTR_W-3:0]})))
        else $error("FIFO flags disagree with gray pointers");

endmodule

`default_nettype wire

/* logic/i2s_rx_fifos.sv */
// ----------------------------------------------------------
// Receive FIFO block for the I2S slave port
// Left, right and mono FIFOs with mode steering
// Mono pair packing, pop source select, flush
// Zeroed left and right data while empty
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "i2s_rx_params.svh"

module i2s_rx_fifos
(
    input  logic                          i2s_clk_i,
    input  logic                          WBs_CLK_i,
    input  logic                          WBs_RST_i,
    input  logic                          flush_i,
    input  i2s_rx_pkg::sample_t           sample_i,
    input  logic                          sample_vld_i,
    input  logic                          stereo_en_i,
    input  logic                          chnl_sel_i,
    input  logic                          dma_busy_i,
    input  logic                          dma_pop_i,
    input  logic                          cpu_pop_i,
    output logic                          i2s_flush_o,
    output logic [`I2S_RX_SAMPLE_W-1:0]   l_data_o,
    output logic [`I2S_RX_SAMPLE_W-1:0]   r_data_o,
    output logic [2*`I2S_RX_SAMPLE_W-1:0] mono_data_o,
    output i2s_rx_pkg::fifo_status_t      l_status_o,
    output i2s_rx_pkg::fifo_status_t      r_status_o,
    output i2s_rx_pkg::fifo_status_t      mono_status_o
);

    logic                        bus_flush;
    logic [1:0]                  i2s_flush_q;
    logic                        l_push;
    logic                        r_push;
    logic                        mono_hit;
    logic                        mono_push;
    logic                        pair_half_q;
    logic [`I2S_RX_SAMPLE_W-1:0] older_q;
    i2s_rx_pkg::mono_word_u      mono_wr;
    i2s_rx_pkg::mono_word_u      mono_rd;
    logic                        pop_req;
    logic                        stereo_pop;
    logic                        mono_pop;
    logic [`I2S_RX_SAMPLE_W-1:0] l_rd_data;
    logic [`I2S_RX_SAMPLE_W-1:0] r_rd_data;

    // ------------------------------------------------------
    // Flush, bus reset included
    // ------------------------------------------------------
    assign bus_flush = WBs_RST_i | flush_i;

    // Enters at once, leaves two bit clocks after the flush drops
    always_ff @(posedge i2s_clk_i or posedge bus_flush)
    begin
        if (bus_flush)
        begin
            i2s_flush_q <= 2'b11;
        end
        else
        begin
            i2s_flush_q <= {i2s_flush_q[0], 1'b0};
        end
    end

    assign i2s_flush_o = i2s_flush_q[1];

    // ------------------------------------------------------
    // Push steering, bit clock domain
    // ------------------------------------------------------
    // Mode and channel select are static while samples flow
    assign l_push    = sample_vld_i & stereo_en_i & ~sample_i.right;
    assign r_push    = sample_vld_i & stereo_en_i & sample_i.right;
    assign mono_hit  = sample_vld_i & ~stereo_en_i & (sample_i.right == chnl_sel_i);
    assign mono_push = mono_hit & pair_half_q;

    always_ff @(posedge i2s_clk_i or posedge i2s_flush_o)
    begin
        if (i2s_flush_o)
        begin
            pair_half_q <= 1'b0;
        end
        else if (mono_hit)
        begin
            pair_half_q <= ~pair_half_q;
        end
    end

    // First sample of a pair waits here
    always_ff @(posedge i2s_clk_i)
    begin
        if (mono_hit && !pair_half_q)
        begin
            older_q <= sample_i.data;
        end
    end

    always_comb
    begin
        mono_wr.pair.older = older_q;
        mono_wr.pair.newer = sample_i.data;
    end

    // Pop source and mode gating, bus clock domain
    assign pop_req    = dma_busy_i ? dma_pop_i : cpu_pop_i;
    assign stereo_pop = pop_req & stereo_en_i;
    assign mono_pop   = pop_req & ~stereo_en_i;

    // ------------------------------------------------------
    // FIFOs
    // ------------------------------------------------------
    i2s_async_fifo #(
        .DATA_W      (`I2S_RX_SAMPLE_W),
        .DEPTH       (`I2S_RX_FIFO_DEPTH)
    ) u_fifo_l (
        .wr_clk_i    (i2s_clk_i),
        .wr_rst_i    (i2s_flush_o),
        .wr_en_i     (l_push),
        .wr_data_i   (sample_i.data),
        .wr_full_o   (),
        .rd_clk_i    (WBs_CLK_i),
        .rd_rst_i    (bus_flush),
        .rd_en_i     (stereo_pop),
        .rd_data_o   (l_rd_data),
        .rd_status_o (l_status_o)
    );

    i2s_async_fifo #(
        .DATA_W      (`I2S_RX_SAMPLE_W),
        .DEPTH       (`I2S_RX_FIFO_DEPTH)
    ) u_fifo_r (
        .wr_clk_i    (i2s_clk_i),
        .wr_rst_i    (i2s_flush_o),
        .wr_en_i     (r_push),
        .wr_data_i   (sample_i.data),
        .wr_full_o   (),
        .rd_clk_i    (WBs_CLK_i),
        .rd_rst_i    (bus_flush),
        .rd_en_i     (stereo_pop),
        .rd_data_o   (r_rd_data),
        .rd_status_o (r_status_o)
    );

    i2s_async_fifo #(
        .DATA_W      (2 * `I2S_RX_SAMPLE_W),
        .DEPTH       (`I2S_RX_FIFO_DEPTH)
    ) u_fifo_mono (
        .wr_clk_i    (i2s_clk_i),
        .wr_rst_i    (i2s_flush_o),
        .wr_en_i     (mono_push),
        .wr_data_i   (mono_wr.raw),
        .wr_full_o   (),
        .rd_clk_i    (WBs_CLK_i),
        .rd_rst_i    (bus_flush),
        .rd_en_i     (mono_pop),
        .rd_data_o   (mono_rd),
        .rd_status_o (mono_status_o)
    );

    // Memory contents are undefined before the first push
    assign l_data_o    = l_status_o.empty ? '0 : l_rd_data;
    assign r_data_o    = r_status_o.empty ? '0 : r_rd_data;
    assign mono_data_o = mono_rd.raw;

endmodule

`default_nettype wire

/* logic/i2s_slave_rx.sv */
// ----------------------------------------------------------
// I2S slave receive top level
// Deserializer feeding the receive FIFO block
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "i2s_rx_params.svh"

module i2s_slave_rx
(
    input  logic                          i2s_clk_i,
    input  logic                          i2s_ws_i,
    input  logic                          i2s_sd_i,
    input  logic                          WBs_CLK_i,
    input  logic                          WBs_RST_i,
    input  logic                          flush_i,
    input  logic                          stereo_en_i,
    input  logic                          chnl_sel_i,
    input  logic                          dma_busy_i,
    input  logic                          dma_pop_i,
    input  logic                          cpu_pop_i,
    output logic [`I2S_RX_SAMPLE_W-1:0]   l_data_o,
    output logic [`I2S_RX_SAMPLE_W-1:0]   r_data_o,
    output logic [2*`I2S_RX_SAMPLE_W-1:0] mono_data_o,
    output i2s_rx_pkg::fifo_status_t      l_status_o,
    output i2s_rx_pkg::fifo_status_t      r_status_o,
    output i2s_rx_pkg::fifo_status_t      mono_status_o
);

    i2s_rx_pkg::sample_t sample;
    logic                sample_vld;
    logic                i2s_flush;

    // Serial side, bit clock domain
    i2s_rx_deserializer u_deser (
        .i2s_clk_i     (i2s_clk_i),
        .rst_i         (i2s_flush),
        .i2s_ws_i      (i2s_ws_i),
        .i2s_sd_i      (i2s_sd_i),
        .sample_o      (sample),
        .sample_vld_o  (sample_vld)
    );

    i2s_rx_fifos u_fifos (
        .i2s_clk_i     (i2s_clk_i),
        .WBs_CLK_i     (WBs_CLK_i),
        .WBs_RST_i     (WBs_RST_i),
        .flush_i       (flush_i),
        .sample_i      (sample),
        .sample_vld_i  (sample_vld),
        .stereo_en_i   (stereo_en_i),
        .chnl_sel_i    (chnl_sel_i),
        .dma_busy_i    (dma_busy_i),
        .dma_pop_i     (dma_pop_i),
        .cpu_pop_i     (cpu_pop_i),
        .i2s_flush_o   (i2s_flush),
        .l_data_o      (l_data_o),
        .r_data_o      (r_data_o),
        .mono_data_o   (mono_data_o),
        .l_status_o    (l_status_o),
        .r_status_o    (r_status_o),
        .mono_status_o (mono_status_o)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
// ----------------------------------------------------------
// Testbench clocks and reset
// 20 ns bus clock, 160 ns I2S bit clock, 3 cycle reset
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen
(
    output logic wbs_clk_o,
    output logic i2s_clk_o,
    output logic wbs_rst_o
);

    initial
    begin
        wbs_clk_o = 1'b0;
        forever #10 wbs_clk_o = ~wbs_clk_o;
    end

    // Edges never coincide with bus rising edges
    initial
    begin
        i2s_clk_o = 1'b0;
        forever #80 i2s_clk_o = ~i2s_clk_o;
    end

    initial
    begin
        wbs_rst_o = 1'b1;
        repeat (3) @(posedge wbs_clk_o);
        wbs_rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/tb_i2s_slave_rx.sv */
// ----------------------------------------------------------
// Testbench for the I2S slave receive path
// Stimulus table, I2S frame driver, queue reference model
// Compare tasks, pop and flush sequences, timeout
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "i2s_rx_params.svh"

module tb_i2s_slave_rx;

    localparam int SW       = `I2S_RX_SAMPLE_W;
    localparam int DEPTH    = `I2S_RX_FIFO_DEPTH;
    localparam int NUM_ROWS = 9;

    // One table row per test step
    typedef struct packed {
        logic          stereo;
        logic          chnl;
        logic          use_dma;
        logic [7:0]    frames;
        logic          flush;
        logic [SW-1:0] base;
    } row_t;

    logic                     wbs_clk;
    logic                     i2s_clk;
    logic                     wbs_rst;
    logic                     i2s_ws;
    logic                     i2s_sd;
    logic                     flush;
    logic                     stereo_en;
    logic                     chnl_sel;
    logic                     dma_busy;
    logic                     dma_pop;
    logic                     cpu_pop;
    logic [SW-1:0]            l_data;
    logic [SW-1:0]            r_data;
    logic [2*SW-1:0]          mono_data;
    i2s_rx_pkg::fifo_status_t l_status;
    i2s_rx_pkg::fifo_status_t r_status;
    i2s_rx_pkg::fifo_status_t mono_status;

    logic [SW-1:0]            exp_l [$];
    logic [SW-1:0]            exp_r [$];
    i2s_rx_pkg::mono_word_u   exp_mono [$];
    logic                     pair_pending;
    logic [SW-1:0]            pair_older;
    row_t                     rows [NUM_ROWS];
    integer                   seed;
    int                       cycle_cnt = 0;
    int                       timeout_limit;

    tb_clk_gen u_clk_gen (
        .wbs_clk_o (wbs_clk),
        .i2s_clk_o (i2s_clk),
        .wbs_rst_o (wbs_rst)
    );

    i2s_slave_rx DUT (
        .i2s_clk_i     (i2s_clk),
        .i2s_ws_i      (i2s_ws),
        .i2s_sd_i      (i2s_sd),
        .WBs_CLK_i     (wbs_clk),
        .WBs_RST_i     (wbs_rst),
        .flush_i       (flush),
        .stereo_en_i   (stereo_en),
        .chnl_sel_i    (chnl_sel),
        .dma_busy_i    (dma_busy),
        .dma_pop_i     (dma_pop),
        .cpu_pop_i     (cpu_pop),
        .l_data_o      (l_data),
        .r_data_o      (r_data),
        .mono_data_o   (mono_data),
        .l_status_o    (l_status),
        .r_status_o    (r_status),
        .mono_status_o (mono_status)
    );

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    task automatic load_table();
        // stereo, chnl_sel, use_dma, frames, flush, sample base
        rows[0] = '{1'b1, 1'b0, 1'b0, 8'd4, 1'b0, 16'h1000};
        rows[1] = '{1'b1, 1'b0, 1'b1, 8'd3, 1'b0, 16'h2000};
        rows[2] = '{1'b0, 1'b0, 1'b0, 8'd4, 1'b0, 16'h3000};
        rows[3] = '{1'b0, 1'b1, 1'b1, 8'd6, 1'b0, 16'h4000};
        // Overflow, depth plus 4 frames
        rows[4] = '{1'b1, 1'b0, 1'b0, 8'(DEPTH + 4), 1'b0, 16'h5000};
        // Odd mono count leaves half a pair for the flush
        rows[5] = '{1'b0, 1'b0, 1'b0, 8'd3, 1'b1, 16'h6000};
        rows[6] = '{1'b0, 1'b0, 1'b0, 8'd4, 1'b0, 16'h7000};
        rows[7] = '{1'b1, 1'b0, 1'b1, 8'd2, 1'b1, 16'h8000};
        rows[8] = '{1'b1, 1'b0, 1'b0, 8'd2, 1'b0, 16'h9000};
    endtask

    function automatic int total_frames();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            sum += int'(rows[i].frames);
        end
        return sum;
    endfunction

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    function automatic i2s_rx_pkg::fifo_status_t expect_status(input int count);
        i2s_rx_pkg::fifo_status_t s;
        s.full  = (count == DEPTH);
        s.empty = (count == 0);
        s.level = `I2S_RX_LEVEL_W'(count);
        return s;
    endfunction

    task automatic check_status(input string name, input i2s_rx_pkg::fifo_status_t got,
                                input i2s_rx_pkg::fifo_status_t exp);
        if (got !== exp)
        begin
            report_fail($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_sample(input string name, input logic [SW-1:0] got,
                                input logic [SW-1:0] exp);
        if (got !== exp)
        begin
            report_fail($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_mono(input string name, input i2s_rx_pkg::mono_word_u got,
                              input i2s_rx_pkg::mono_word_u exp);
        if (got.raw !== exp.raw)
        begin
            report_fail($sformatf("CHECK FAILED %s got %h expected %h", name, got.raw,
                                  exp.raw));
        end
    endtask

    // ------------------------------------------------------------
    // I2S frame driver and reference model
    // ------------------------------------------------------------
    task automatic send_bit(input logic ws, input logic sd);
        @(negedge i2s_clk);
        i2s_ws <= ws;
        i2s_sd <= sd;
    endtask

    // Word select moves to the next channel during the LSB
    task automatic send_word(input logic ws, input logic ws_next, input logic [SW-1:0] data);
        for (int b = SW - 1; b >= 0; b--)
        begin
            send_bit((b == 0) ? ws_next : ws, data[b]);
        end
    endtask

    task automatic model_sample(input row_t row, input logic right, input logic [SW-1:0] data);
        i2s_rx_pkg::mono_word_u w;
        if (row.stereo)
        begin
            if (!right && exp_l.size() < DEPTH)
                exp_l.push_back(data);
            if (right && exp_r.size() < DEPTH)
                exp_r.push_back(data);
        end
        else if (right == row.chnl)
        begin
            if (pair_pending)
            begin
                // Older sample in the low half
                w.raw = {data, pair_older};
                if (exp_mono.size() < DEPTH)
                    exp_mono.push_back(w);
            end
            pair_older   = data;
            pair_pending = ~pair_pending;
        end
    endtask

    task automatic send_frames(input row_t row);
        logic [31:0]   rnd;
        logic [SW-1:0] left;
        logic [SW-1:0] right;
        // Lead-in bit, word select low one bit before the first MSB
        send_bit(1'b0, 1'b0);
        for (int f = 0; f < int'(row.frames); f++)
        begin
            rnd   = $random(seed);
            left  = row.base + rnd[SW-1:0];
            right = (row.base ^ 16'h5a5a) + rnd[31:16];
            send_word(1'b0, 1'b1, left);
            // Last right word keeps word select high, line goes idle
            send_word(1'b1, (f == int'(row.frames) - 1), right);
            model_sample(row, 1'b0, left);
            model_sample(row, 1'b1, right);
        end
        send_bit(1'b1, 1'b0);
    endtask

    // ------------------------------------------------------------
    // Bus side sequences
    // ------------------------------------------------------------
    task automatic wait_levels();
        do
        begin
            @(negedge wbs_clk);
        end
        while (int'(l_status.level) != exp_l.size() || int'(r_status.level) != exp_r.size()
               || int'(mono_status.level) != exp_mono.size());
    endtask

    task automatic pulse_pop(input logic use_dma);
        @(posedge wbs_clk);
        if (use_dma)
            dma_pop <= 1'b1;
        else
            cpu_pop <= 1'b1;
        @(posedge wbs_clk);
        dma_pop <= 1'b0;
        cpu_pop <= 1'b0;
    endtask

    task automatic drain_stereo(input logic use_dma);
        // Strobe of the inactive source must pop nothing
        pulse_pop(!use_dma);
        while (exp_l.size() > 0)
        begin
            @(negedge wbs_clk);
            check_status("l_status_o", l_status, expect_status(exp_l.size()));
            check_status("r_status_o", r_status, expect_status(exp_r.size()));
            check_sample("l_data_o", l_data, exp_l[0]);
            check_sample("r_data_o", r_data, exp_r[0]);
            pulse_pop(use_dma);
            void'(exp_l.pop_front());
            void'(exp_r.pop_front());
        end
        @(negedge wbs_clk);
        check_status("l_status_o", l_status, expect_status(0));
        check_status("r_status_o", r_status, expect_status(0));
        check_sample("l_data_o", l_data, '0);
        check_sample("r_data_o", r_data, '0);
    endtask

    task automatic drain_mono(input logic use_dma);
        i2s_rx_pkg::mono_word_u got;
        pulse_pop(!use_dma);
        while (exp_mono.size() > 0)
        begin
            @(negedge wbs_clk);
            got.raw = mono_data;
            check_status("mono_status_o", mono_status, expect_status(exp_mono.size()));
            check_status("l_status_o", l_status, expect_status(0));
            check_status("r_status_o", r_status, expect_status(0));
            check_mono("mono_data_o", got, exp_mono[0]);
            pulse_pop(use_dma);
            void'(exp_mono.pop_front());
        end
        @(negedge wbs_clk);
        check_status("mono_status_o", mono_status, expect_status(0));
    endtask

    task automatic apply_flush();
        @(posedge wbs_clk);
        flush <= 1'b1;
        // Longer than two bit clocks
        repeat (20) @(posedge wbs_clk);
        flush <= 1'b0;
        @(negedge wbs_clk);
        check_status("l_status_o", l_status, expect_status(0));
        check_status("r_status_o", r_status, expect_status(0));
        check_status("mono_status_o", mono_status, expect_status(0));
        exp_l.delete();
        exp_r.delete();
        exp_mono.delete();
        pair_pending = 1'b0;
        // Bit clock side leaves flush two bit clocks later
        repeat (4) @(negedge i2s_clk);
    endtask

    task automatic run_row(input row_t row);
        @(posedge wbs_clk);
        stereo_en <= row.stereo;
        chnl_sel  <= row.chnl;
        dma_busy  <= row.use_dma;
        send_frames(row);
        wait_levels();
        if (row.flush)
            apply_flush();
        else if (row.stereo)
            drain_stereo(row.use_dma);
        else
            drain_mono(row.use_dma);
    endtask

    // Run limit from the table length
    always @(posedge wbs_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit)
        begin
            $display("Timeout, run did not finish within %0d bus cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        seed         = 52363;
        i2s_ws       = 1'b1;
        i2s_sd       = 1'b0;
        flush        = 1'b0;
        stereo_en    = 1'b1;
        chnl_sel     = 1'b0;
        dma_busy     = 1'b0;
        dma_pop      = 1'b0;
        cpu_pop      = 1'b0;
        pair_pending = 1'b0;
        pair_older   = '0;
        load_table();
        timeout_limit = total_frames() * 32 * 8 + 2000;

        while (wbs_rst)
            @(negedge wbs_clk);
        @(negedge wbs_clk);
        check_status("l_status_o", l_status, expect_status(0));
        check_status("r_status_o", r_status, expect_status(0));
        check_status("mono_status_o", mono_status, expect_status(0));
        check_sample("l_data_o", l_data, '0);
        check_sample("r_data_o", r_data, '0);
        repeat (4) @(negedge i2s_clk);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            run_row(rows[i]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* i2s_slave_rx.f */
+incdir+include
logic/i2s_rx_pkg.sv
logic/i2s_rx_deserializer.sv
logic/i2s_async_fifo.sv
logic/i2s_rx_fifos.sv
logic/i2s_slave_rx.sv
tb/tb_clk_gen.sv
tb/tb_i2s_slave_rx.sv

/* Makefile */
# Verilator build and run for the I2S slave receive testbench

SIM        = verilator
TOP        = tb_i2s_slave_rx
FILELIST   = i2s_slave_rx.f
VFLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
